//--- tb.f
verilog/fft_pkg.sv
verilog/fft_apb_regs.sv
verilog/fft_ctrl.sv
verilog/fft_twiddle_rom.sv
verilog/fft_butterfly.sv
verilog/fft_sample_ram.sv
verilog/fft_core_top.sv
verification/fft_tb.sv

//--- Bender.yml
package:
  name: fft_core

sources:
  - verilog/fft_pkg.sv
  - verilog/fft_apb_regs.sv
  - verilog/fft_ctrl.sv
  - verilog/fft_twiddle_rom.sv
  - verilog/fft_butterfly.sv
  - verilog/fft_sample_ram.sv
  - verilog/fft_core_top.sv
  - target: test
    files:
      - verification/fft_tb.sv

//--- verification/fft_tb.sv
`timescale 1ns/1ps

module fft_tb;

	localparam int FFT_CYCLES = 4 * (8 + 2) + 1;
	localparam int APB_CYCLES = 16 * 3 + 16 * 4 + 12; // writes, result reads, start, status.
	localparam int FRAMES = 7;
	localparam int MAX_CYCLES = 3 * FRAMES * (FFT_CYCLES + APB_CYCLES) + 20;

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	int seed;
	int cycles = 0;
	int frames_read = 0;
	int frames_checked = 0;
	int in_re [0:15];
	int in_im [0:15];
	int exp_re [0:15];
	int exp_im [0:15];
	int got_re [0:15];
	int got_im [0:15];
	logic err;
	logic [31:0] rdata;

	fft_core_top DUT
	(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic int rev_index(input int i);
		return ((i & 1) << 3) | ((i & 2) << 1) | ((i & 4) >> 1) | ((i & 8) >> 3);
	endfunction

	// in-place DIT on the frame in in_re/in_im with a halving per stage.
	function automatic void ref_fft();
		int xr [0:15];
		int xi [0:15];
		int span;
		int a;
		int b;
		int k;
		int wr;
		int wi;
		int pr;
		int pi;
		for (int i = 0; i < 16; i++)
		begin
			xr[rev_index(i)] = in_re[i];
			xi[rev_index(i)] = in_im[i];
		end
		for (int s = 0; s < 4; s++)
		begin
			span = 1 << s;
			for (int g = 0; g < 16; g += 2 * span)
			begin
				for (int j = 0; j < span; j++)
				begin
					a = g + j;
					b = a + span;
					k = (j * 8) >> s;
					wr = fft_pkg::TW_COS[k];
					wi = -int'(fft_pkg::TW_SIN[k]); // w = cos - j sin.
					pr = (xr[b] * wr - xi[b] * wi) >>> 14;
					pi = (xr[b] * wi + xi[b] * wr) >>> 14;
					xr[b] = int'(shortint'((xr[a] - pr) >>> 1));
					xi[b] = int'(shortint'((xi[a] - pi) >>> 1));
					xr[a] = int'(shortint'((xr[a] + pr) >>> 1));
					xi[a] = int'(shortint'((xi[a] + pi) >>> 1));
				end
			end
		end
		for (int i = 0; i < 16; i++)
		begin
			exp_re[i] = xr[i];
			exp_im[i] = xi[i];
		end
	endfunction

	task automatic check(input int expected, input int actual, input string what);
		if (expected !== actual)
		begin
			$display("[FAIL] %0t: %s expected %0d got %0d", $time, what, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic e);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		while (!pready)
			@(negedge clk);
		e = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic e);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		while (!pready)
			@(negedge clk);
		data = prdata;
		e = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_frame();
		logic e;
		for (int k = 0; k < 16; k++)
		begin
			apb_write(8'(fft_pkg::ADDR_DATA + 4 * k), {16'(in_im[k]), 16'(in_re[k])}, e);
			check(0, int'(e), $sformatf("pslverr on sample %0d write", k));
		end
	endtask

	task automatic start_frame();
		logic e;
		logic [31:0] status;
		apb_write(fft_pkg::ADDR_CTRL, 32'h1, e);
		check(0, int'(e), "pslverr on start");
		apb_read(fft_pkg::ADDR_STATUS, status, e);
		check(1, int'(status), "status after start"); // busy set and done cleared.
	endtask

	task automatic wait_done();
		logic e;
		logic [31:0] status;
		status = 32'h1;
		while (status[0])
			apb_read(fft_pkg::ADDR_STATUS, status, e);
		check(2, int'(status), "status at completion");
	endtask

	task automatic read_results();
		logic e;
		logic [31:0] data;
		for (int k = 0; k < 16; k++)
		begin
			apb_read(8'(fft_pkg::ADDR_DATA + 4 * k), data, e);
			check(0, int'(e), $sformatf("pslverr on result %0d read", k));
			got_re[k] = $signed(data[15:0]);
			got_im[k] = $signed(data[31:16]);
		end
		frames_read = frames_read + 1;
		wait (frames_checked == frames_read);
	endtask

	task automatic run_frame();
		write_frame();
		start_frame();
		wait_done();
		read_results();
	endtask

	task automatic random_frame();
		for (int k = 0; k < 16; k++)
		begin
			in_re[k] = $random(seed) % 4096;
			in_im[k] = $random(seed) % 4096;
		end
	endtask

	// compares each frame read back against the reference model.
	initial
	begin
		forever
		begin
			wait (frames_read > frames_checked);
			ref_fft();
			for (int k = 0; k < 16; k++)
			begin
				check(exp_re[k], got_re[k],
					$sformatf("frame %0d bin %0d re", frames_checked, k));
				check(exp_im[k], got_im[k],
					$sformatf("frame %0d bin %0d im", frames_checked, k));
			end
			frames_checked = frames_checked + 1;
		end
	end

	initial
	begin
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 32'h50c68c9a;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		apb_read(fft_pkg::ADDR_STATUS, rdata, err);
		check(0, int'(rdata), "status after reset");
		check(0, int'(err), "pslverr on status read");

		// an impulse spreads 16384 / 16 over every bin.
		for (int k = 0; k < 16; k++)
		begin
			in_re[k] = (k == 0) ? 16384 : 0;
			in_im[k] = 0;
		end
		run_frame();
		for (int k = 0; k < 16; k++)
		begin
			check(1024, got_re[k], $sformatf("impulse bin %0d re", k));
			check(0, got_im[k], $sformatf("impulse bin %0d im", k));
		end

		// constant input lands in bin 0 only.
		for (int k = 0; k < 16; k++)
		begin
			in_re[k] = 2000;
			in_im[k] = -500;
		end
		run_frame();
		for (int k = 0; k < 16; k++)
		begin
			check((k == 0) ? 2000 : 0, got_re[k], $sformatf("constant bin %0d re", k));
			check((k == 0) ? -500 : 0, got_im[k], $sformatf("constant bin %0d im", k));
		end
		apb_read(fft_pkg::ADDR_STATUS, rdata, err);
		check(2, int'(rdata), "done still set after result reads");

		repeat (4)
		begin
			random_frame();
			run_frame();
		end

		// errors while the engine runs.
		random_frame();
		write_frame();
		start_frame();
		apb_write(8'(fft_pkg::ADDR_DATA + 12), 32'h0fff0fff, err);
		check(1, int'(err), "pslverr on sample write while busy");
		apb_write(fft_pkg::ADDR_CTRL, 32'h1, err);
		check(1, int'(err), "pslverr on start while busy");
		wait_done();
		read_results();

		apb_read(8'h20, rdata, err);
		check(1, int'(err), "pslverr on unmapped read");
		apb_write(8'h20, 32'h1, err);
		check(1, int'(err), "pslverr on unmapped write");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- verilog/fft_core_top.sv
`timescale 1ns/1ps

module fft_core_top
(
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [2*fft_pkg::DW-1:0] pwdata,
	output logic [2*fft_pkg::DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic start;
	logic busy;
	logic done;
	logic host_we;
	logic [fft_pkg::LOG2N-1:0] host_addr;
	logic signed [fft_pkg::DW-1:0] host_wre;
	logic signed [fft_pkg::DW-1:0] host_wim;
	logic signed [fft_pkg::DW-1:0] host_rre;
	logic signed [fft_pkg::DW-1:0] host_rim;
	logic [fft_pkg::LOG2N-1:0] rd_addr_a;
	logic [fft_pkg::LOG2N-1:0] rd_addr_b;
	logic [fft_pkg::LOG2N-2:0] tw_idx;
	logic in_valid;
	logic wr_en;
	logic [fft_pkg::LOG2N-1:0] wr_addr_a;
	logic [fft_pkg::LOG2N-1:0] wr_addr_b;
	logic signed [fft_pkg::DW-1:0] tw_re;
	logic signed [fft_pkg::DW-1:0] tw_im;
	logic signed [fft_pkg::DW-1:0] rd_re_a;
	logic signed [fft_pkg::DW-1:0] rd_im_a;
	logic signed [fft_pkg::DW-1:0] rd_re_b;
	logic signed [fft_pkg::DW-1:0] rd_im_b;
	logic signed [fft_pkg::DW-1:0] out_re_a;
	logic signed [fft_pkg::DW-1:0] out_im_a;
	logic signed [fft_pkg::DW-1:0] out_re_b;
	logic signed [fft_pkg::DW-1:0] out_im_b;

	fft_apb_regs apb_regs
	(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.done(done),
		.host_rre(host_rre),
		.host_rim(host_rim),
		.start(start),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wre(host_wre),
		.host_wim(host_wim)
	);

	fft_ctrl ctrl
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.tw_idx(tw_idx),
		.in_valid(in_valid),
		.wr_en(wr_en),
		.wr_addr_a(wr_addr_a),
		.wr_addr_b(wr_addr_b)
	);

	fft_twiddle_rom twiddle_rom
	(
		.clk(clk),
		.tw_idx(tw_idx),
		.tw_re(tw_re),
		.tw_im(tw_im)
	);

	// in_valid is already one cycle behind the issued addresses.
	fft_butterfly butterfly
	(
		.clk(clk),
		.rst(rst),
		.bf_valid(in_valid),
		.a_re(rd_re_a),
		.a_im(rd_im_a),
		.b_re(rd_re_b),
		.b_im(rd_im_b),
		.tw_re(tw_re),
		.tw_im(tw_im),
		.out_re_a(out_re_a),
		.out_im_a(out_im_a),
		.out_re_b(out_re_b),
		.out_im_b(out_im_b)
	);

	fft_sample_ram sample_ram
	(
		.clk(clk),
		.busy(busy),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wre(host_wre),
		.host_wim(host_wim),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.wr_en(wr_en),
		.wr_addr_a(wr_addr_a),
		.wr_addr_b(wr_addr_b),
		.wr_re_a(out_re_a),
		.wr_im_a(out_im_a),
		.wr_re_b(out_re_b),
		.wr_im_b(out_im_b),
		.host_rre(host_rre),
		.host_rim(host_rim),
		.rd_re_a(rd_re_a),
		.rd_im_a(rd_im_a),
		.rd_re_b(rd_re_b),
		.rd_im_b(rd_im_b)
	);

endmodule

//--- verilog/fft_sample_ram.sv
`timescale 1ns/1ps

module fft_sample_ram
(
	input  logic clk,
	input  logic busy,
	input  logic host_we,
	input  logic [fft_pkg::LOG2N-1:0] host_addr,
	input  logic signed [fft_pkg::DW-1:0] host_wre,
	input  logic signed [fft_pkg::DW-1:0] host_wim,
	input  logic [fft_pkg::LOG2N-1:0] rd_addr_a,
	input  logic [fft_pkg::LOG2N-1:0] rd_addr_b,
	input  logic wr_en,
	input  logic [fft_pkg::LOG2N-1:0] wr_addr_a,
	input  logic [fft_pkg::LOG2N-1:0] wr_addr_b,
	input  logic signed [fft_pkg::DW-1:0] wr_re_a,
	input  logic signed [fft_pkg::DW-1:0] wr_im_a,
	input  logic signed [fft_pkg::DW-1:0] wr_re_b,
	input  logic signed [fft_pkg::DW-1:0] wr_im_b,
	output logic signed [fft_pkg::DW-1:0] host_rre,
	output logic signed [fft_pkg::DW-1:0] host_rim,
	output logic signed [fft_pkg::DW-1:0] rd_re_a,
	output logic signed [fft_pkg::DW-1:0] rd_im_a,
	output logic signed [fft_pkg::DW-1:0] rd_re_b,
	output logic signed [fft_pkg::DW-1:0] rd_im_b
);

	logic signed [fft_pkg::DW-1:0] mem_re [0:fft_pkg::FFT_N-1];
	logic signed [fft_pkg::DW-1:0] mem_im [0:fft_pkg::FFT_N-1];

	always_ff @(posedge clk)
	begin
		if (busy)
		begin
			if (wr_en)
			begin
				mem_re[wr_addr_a] <= wr_re_a;
				mem_im[wr_addr_a] <= wr_im_a;
				mem_re[wr_addr_b] <= wr_re_b;
				mem_im[wr_addr_b] <= wr_im_b;
			end
		end
		else if (host_we)
		begin
			mem_re[host_addr] <= host_wre;
			mem_im[host_addr] <= host_wim;
		end
	end

	always_ff @(posedge clk)
	begin
		rd_re_a <= mem_re[rd_addr_a];
		rd_im_a <= mem_im[rd_addr_a];
		rd_re_b <= mem_re[rd_addr_b];
		rd_im_b <= mem_im[rd_addr_b];
		host_rre <= mem_re[host_addr];
		host_rim <= mem_im[host_addr];
	end

	assert property (@(posedge clk) wr_en |-> wr_addr_a != wr_addr_b);
	assert property (@(posedge clk) busy |-> !host_we);

endmodule

//--- verilog/fft_butterfly.sv
`timescale 1ns/1ps

module fft_butterfly
(
	input  logic clk,
	input  logic rst,
	input  logic bf_valid,
	input  logic signed [fft_pkg::DW-1:0] a_re,
	input  logic signed [fft_pkg::DW-1:0] a_im,
	input  logic signed [fft_pkg::DW-1:0] b_re,
	input  logic signed [fft_pkg::DW-1:0] b_im,
	input  logic signed [fft_pkg::DW-1:0] tw_re,
	input  logic signed [fft_pkg::DW-1:0] tw_im,
	output logic signed [fft_pkg::DW-1:0] out_re_a,
	output logic signed [fft_pkg::DW-1:0] out_im_a,
	output logic signed [fft_pkg::DW-1:0] out_re_b,
	output logic signed [fft_pkg::DW-1:0] out_im_b
);

	logic signed [2*fft_pkg::DW:0] prod_re;
	logic signed [2*fft_pkg::DW:0] prod_im;
	logic signed [fft_pkg::DW+1:0] p_re;
	logic signed [fft_pkg::DW+1:0] p_im;
	logic signed [fft_pkg::DW-1:0] a_re_q;
	logic signed [fft_pkg::DW-1:0] a_im_q;
	logic signed [fft_pkg::DW+2:0] sum_re;
	logic signed [fft_pkg::DW+2:0] sum_im;
	logic signed [fft_pkg::DW+2:0] dif_re;
	logic signed [fft_pkg::DW+2:0] dif_im;
	logic p_valid;

	always_comb
	begin
		prod_re = b_re * tw_re - b_im * tw_im;
		prod_im = b_re * tw_im + b_im * tw_re;
		sum_re = a_re_q + p_re;
		sum_im = a_im_q + p_im;
		dif_re = a_re_q - p_re;
		dif_im = a_im_q - p_im;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			p_valid <= 1'b0;
		else
			p_valid <= bf_valid;
	end

	always_ff @(posedge clk)
	begin
		if (bf_valid)
		begin
			p_re <= prod_re[fft_pkg::TW_FRAC +: fft_pkg::DW+2]; // truncating >>> 14.
			p_im <= prod_im[fft_pkg::TW_FRAC +: fft_pkg::DW+2];
			a_re_q <= a_re;
			a_im_q <= a_im;
		end
		if (p_valid)
		begin
			out_re_a <= sum_re[fft_pkg::DW:1]; // halved.
			out_im_a <= sum_im[fft_pkg::DW:1];
			out_re_b <= dif_re[fft_pkg::DW:1];
			out_im_b <= dif_im[fft_pkg::DW:1];
		end
	end

endmodule

//--- verilog/fft_twiddle_rom.sv
`timescale 1ns/1ps

module fft_twiddle_rom
(
	input  logic clk,
	input  logic [fft_pkg::LOG2N-2:0] tw_idx,
	output logic signed [fft_pkg::DW-1:0] tw_re,
	output logic signed [fft_pkg::DW-1:0] tw_im
);

	// W = cos - j*sin registered one cycle behind the index.
	always_ff @(posedge clk)
	begin
		tw_re <= fft_pkg::TW_COS[tw_idx];
		tw_im <= -fft_pkg::TW_SIN[tw_idx];
	end

endmodule

//--- verilog/fft_ctrl.sv
`timescale 1ns/1ps

module fft_ctrl
(
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic busy,
	output logic done,
	output logic [fft_pkg::LOG2N-1:0] rd_addr_a,
	output logic [fft_pkg::LOG2N-1:0] rd_addr_b,
	output logic [fft_pkg::LOG2N-2:0] tw_idx,
	output logic in_valid,
	output logic wr_en,
	output logic [fft_pkg::LOG2N-1:0] wr_addr_a,
	output logic [fft_pkg::LOG2N-1:0] wr_addr_b
);

	logic run;
	logic [$clog2(fft_pkg::LOG2N):0] stage;
	logic [fft_pkg::LOG2N-2:0] bfly;
	logic [fft_pkg::BF_LAT-1:0] drain;
	logic issue;
	logic last;
	logic [fft_pkg::LOG2N-1:0] span;
	logic [fft_pkg::LOG2N-1:0] pos;
	logic [fft_pkg::LOG2N-1:0] grp;
	logic [2*fft_pkg::LOG2N-2:0] tw_wide;
	logic [fft_pkg::BF_LAT:0] v_dly;
	logic [fft_pkg::BF_LAT:0] last_dly;
	logic [fft_pkg::LOG2N-1:0] a_dly [0:fft_pkg::BF_LAT];
	logic [fft_pkg::LOG2N-1:0] b_dly [0:fft_pkg::BF_LAT];

	// in-place DIT pair for the current stage and butterfly.
	always_comb
	begin
		issue = run && (drain == '0);
		span = {{(fft_pkg::LOG2N-1){1'b0}}, 1'b1} << stage;
		pos = {1'b0, bfly} & (span - 1'b1);
		grp = {1'b0, bfly} >> stage;
		rd_addr_a = (grp << (stage + 1'b1)) | pos;
		rd_addr_b = rd_addr_a | span;
		tw_wide = {pos, {(fft_pkg::LOG2N-1){1'b0}}} >> stage; // pos * N/2 >> s.
		tw_idx = tw_wide[fft_pkg::LOG2N-2:0];
		last = issue && (stage == fft_pkg::LOG2N - 1) && (bfly == '1);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			run <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			stage <= '0;
			bfly <= '0;
			drain <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start && !busy)
			begin
				run <= 1'b1;
				busy <= 1'b1;
				stage <= '0;
				bfly <= '0;
				drain <= '0;
			end
			else if (run)
			begin
				if (drain != '0)
					drain <= drain >> 1;
				else if (bfly != '1)
					bfly <= bfly + 1'b1;
				else
				begin
					bfly <= '0;
					if (stage == fft_pkg::LOG2N - 1)
						run <= 1'b0;
					else
					begin
						stage <= stage + 1'b1;
						drain <= '1; // let the pipeline write back first.
					end
				end
			end
			if (wr_en && last_dly[fft_pkg::BF_LAT])
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v_dly <= '0;
			last_dly <= '0;
		end
		else
		begin
			v_dly <= {v_dly[fft_pkg::BF_LAT-1:0], issue};
			last_dly <= {last_dly[fft_pkg::BF_LAT-1:0], last};
		end
	end

	always_ff @(posedge clk)
	begin
		a_dly[0] <= rd_addr_a;
		b_dly[0] <= rd_addr_b;
		for (int i = 1; i <= fft_pkg::BF_LAT; i++)
		begin
			a_dly[i] <= a_dly[i-1];
			b_dly[i] <= b_dly[i-1];
		end
	end

	assign in_valid = v_dly[0]; // lines up with ram and rom data.
	assign wr_en = v_dly[fft_pkg::BF_LAT];
	assign wr_addr_a = a_dly[fft_pkg::BF_LAT];
	assign wr_addr_b = b_dly[fft_pkg::BF_LAT];

	assert property (@(posedge clk) disable iff (rst) busy |-> stage <= fft_pkg::LOG2N - 1);

endmodule

//--- verilog/fft_apb_regs.sv
`timescale 1ns/1ps

module fft_apb_regs
(
	input  logic clk,
	input  logic rst,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [2*fft_pkg::DW-1:0] pwdata,
	output logic [2*fft_pkg::DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic busy,
	input  logic done,
	input  logic signed [fft_pkg::DW-1:0] host_rre,
	input  logic signed [fft_pkg::DW-1:0] host_rim,
	output logic start,
	output logic host_we,
	output logic [fft_pkg::LOG2N-1:0] host_addr,
	output logic signed [fft_pkg::DW-1:0] host_wre,
	output logic signed [fft_pkg::DW-1:0] host_wim
);

	logic [7:0] data_off;
	logic [fft_pkg::LOG2N-1:0] idx;
	logic is_ctrl;
	logic is_status;
	logic is_data;
	logic rd_result;
	logic err;
	logic setup;
	logic xfer;
	logic done_flag;

	function automatic logic [fft_pkg::LOG2N-1:0] bit_rev(input logic [fft_pkg::LOG2N-1:0] a);
		logic [fft_pkg::LOG2N-1:0] r;
		for (int i = 0; i < fft_pkg::LOG2N; i++)
			r[i] = a[fft_pkg::LOG2N-1-i];
		return r;
	endfunction

	always_comb
	begin
		data_off = paddr - fft_pkg::ADDR_DATA;
		is_ctrl = (paddr == fft_pkg::ADDR_CTRL);
		is_status = (paddr == fft_pkg::ADDR_STATUS);
		is_data = ((data_off >> 2) < 8'(fft_pkg::FFT_N)) && (data_off[1:0] == 2'b00);
		idx = data_off[fft_pkg::LOG2N+1:2];
		rd_result = is_data && !pwrite;
		err = !(is_ctrl || is_status || is_data)
			|| (pwrite && is_data && busy)
			|| (pwrite && is_ctrl && pwdata[0] && busy);
		setup = psel && !penable;
		xfer = psel && penable && pready;
	end

	// samples land at bit-reversed slots and results read back in order.
	assign host_addr = pwrite ? bit_rev(idx) : idx;
	assign host_wre = pwdata[fft_pkg::DW-1:0];
	assign host_wim = pwdata[2*fft_pkg::DW-1:fft_pkg::DW];
	assign host_we = xfer && pwrite && is_data && !pslverr;
	assign start = xfer && pwrite && is_ctrl && pwdata[0] && !pslverr;

	always_comb
	begin
		prdata = '0;
		if (is_status)
			prdata[1:0] = {done_flag || done, busy};
		else if (is_data)
			prdata = {host_rim, host_rre};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end
		else
		begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			if (setup)
			begin
				pready <= !rd_result; // result reads wait one cycle.
				pslverr <= err;
			end
			else if (psel && penable && !pready)
				pready <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			done_flag <= 1'b0;
		else if (start)
			done_flag <= 1'b0;
		else if (done)
			done_flag <= 1'b1; // sticky until next start.
	end

	assert property (@(posedge clk) disable iff (rst) $rose(pready) |-> psel && penable);
	assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

//--- verilog/fft_pkg.sv
package fft_pkg;

	localparam int FFT_N = 16;
	localparam int LOG2N = 4; // stages and address bits.
	localparam int DW = 16;
	localparam int TW_FRAC = 14;
	localparam int BF_LAT = 2;

	// byte offsets on the APB side.
	localparam logic [7:0] ADDR_CTRL = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;
	localparam logic [7:0] ADDR_DATA = 8'h40;

	// Q1.14 twiddles of cos and sin at 2*pi*k/16.
	localparam logic signed [DW-1:0] TW_COS [0:FFT_N/2-1] = '{
		16'sd16384,
		16'sd15137,
		16'sd11585,
		16'sd6270,
		16'sd0,
		-16'sd6270,
		-16'sd11585,
		-16'sd15137
	};

	localparam logic signed [DW-1:0] TW_SIN [0:FFT_N/2-1] = '{
		16'sd0,
		16'sd6270,
		16'sd11585,
		16'sd15137,
		16'sd16384,
		16'sd15137,
		16'sd11585,
		16'sd6270
	};

endpackage
